// ==== Bender.yml ====
package:
  name: wbb

sources:
  - rtl/wbb_pkg.sv
  - rtl/wbb_credit_fifo.sv
  - rtl/wbb_cmd_parser.sv
  - rtl/wbb_resp_serializer.sv
  - rtl/wbb_reg_slave.sv
  - rtl/wbb_bridge_top.sv
  - target: simulation
    files:
      - tb/wbb_clk_gen.sv
      - tb/wbb_checker.sv
      - tb/wbb_tb.sv

// ==== rtl/wbb_bridge_top.sv ====
`timescale 1ns/1ps

module wbb_bridge_top #(
  parameter int IN_DEPTH    = 8,
  parameter int RESP_DEPTH  = 4,
  parameter int OUT_CREDITS = 4,
  parameter int MEM_WORDS   = 16
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        in_valid_i,
  input  logic [wbb_pkg::byte_w-1:0]  in_data_i,
  output logic                        in_credit_o,
  output logic                        out_valid_o,
  output logic [wbb_pkg::byte_w-1:0]  out_data_o,
  input  logic                        out_credit_i
);

  logic [wbb_pkg::byte_w-1:0]  in_byte;
  logic                        in_byte_valid;
  logic                        in_byte_pop;
  logic                        in_overflow;

  wbb_pkg::resp_t              resp_in;
  wbb_pkg::resp_t              resp_out;
  logic                        resp_push;
  logic                        resp_full;
  logic                        resp_valid;
  logic                        resp_pop;

  logic                        wb_cyc;
  logic                        wb_stb;
  logic                        wb_we;
  logic [wbb_pkg::addr_w-1:0]  wb_adr;
  logic [wbb_pkg::data_w-1:0]  wb_dat_w;
  logic [wbb_pkg::data_w-1:0]  wb_dat_r;
  logic                        wb_ack;
  logic                        wb_err;

  // The host holds IN_DEPTH credits, so this queue fills only on a protocol breach.
  wbb_credit_fifo #(
    .DEPTH (IN_DEPTH),
    .T     (logic [wbb_pkg::byte_w-1:0])
  ) i_in_fifo (
    .clk        (clk),
    .reset      (reset),
    .push_i     (in_valid_i),
    .data_i     (in_data_i),
    .pop_i      (in_byte_pop),
    .data_o     (in_byte),
    .valid_o    (in_byte_valid),
    .full_o     (),
    .credit_o   (in_credit_o),
    .overflow_o (in_overflow)
  );

  wbb_cmd_parser i_cmd_parser (
    .clk          (clk),
    .reset        (reset),
    .byte_valid_i (in_byte_valid),
    .byte_i       (in_byte),
    .byte_pop_o   (in_byte_pop),
    .overflow_i   (in_overflow),
    .resp_full_i  (resp_full),
    .resp_push_o  (resp_push),
    .resp_o       (resp_in),
    .wb_cyc_o     (wb_cyc),
    .wb_stb_o     (wb_stb),
    .wb_we_o      (wb_we),
    .wb_adr_o     (wb_adr),
    .wb_dat_o     (wb_dat_w),
    .wb_dat_i     (wb_dat_r),
    .wb_ack_i     (wb_ack),
    .wb_err_i     (wb_err)
  );

  wbb_credit_fifo #(
    .DEPTH (RESP_DEPTH),
    .T     (wbb_pkg::resp_t)
  ) i_resp_fifo (
    .clk        (clk),
    .reset      (reset),
    .push_i     (resp_push),
    .data_i     (resp_in),
    .pop_i      (resp_pop),
    .data_o     (resp_out),
    .valid_o    (resp_valid),
    .full_o     (resp_full),
    .credit_o   (),
    .overflow_o ()
  );

  wbb_resp_serializer #(
    .OUT_CREDITS (OUT_CREDITS)
  ) i_resp_serializer (
    .clk          (clk),
    .reset        (reset),
    .rec_valid_i  (resp_valid),
    .rec_i        (resp_out),
    .rec_pop_o    (resp_pop),
    .out_valid_o  (out_valid_o),
    .out_data_o   (out_data_o),
    .out_credit_i (out_credit_i)
  );

  wbb_reg_slave #(
    .MEM_WORDS (MEM_WORDS)
  ) i_reg_slave (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack),
    .wb_err_o (wb_err)
  );

endmodule

// ==== rtl/wbb_cmd_parser.sv ====
`timescale 1ns/1ps

module wbb_cmd_parser (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         byte_valid_i,
  input  logic [wbb_pkg::byte_w-1:0]   byte_i,
  output logic                         byte_pop_o,
  input  logic                         overflow_i,
  input  logic                         resp_full_i,
  output logic                         resp_push_o,
  output wbb_pkg::resp_t               resp_o,
  output logic                         wb_cyc_o,
  output logic                         wb_stb_o,
  output logic                         wb_we_o,
  output logic [wbb_pkg::addr_w-1:0]   wb_adr_o,
  output logic [wbb_pkg::data_w-1:0]   wb_dat_o,
  input  logic [wbb_pkg::data_w-1:0]   wb_dat_i,
  input  logic                         wb_ack_i,
  input  logic                         wb_err_i
);

  localparam int bw = wbb_pkg::byte_w;

  typedef enum logic [1:0] {
    st_command,
    st_collect,
    st_bus_wait,
    st_respond
  } state_t;

  state_t                      state;
  logic [1:0]                  collect_cnt;
  logic                        is_write;
  logic [wbb_pkg::addr_w-1:0]  addr_q;
  logic [wbb_pkg::data_w-1:0]  data_q;
  logic                        bus_q;
  logic                        ovf_sticky;
  logic                        ovf_take;
  wbb_pkg::resp_t              resp_q;

  // A pending overflow report takes priority over the next command byte.
  assign ovf_take   = (state == st_command) && ovf_sticky;
  assign byte_pop_o = byte_valid_i &&
                      (((state == st_command) && !ovf_sticky) || (state == st_collect));

  assign resp_push_o = (state == st_respond) && !resp_full_i;
  assign resp_o      = resp_q;

  assign wb_cyc_o = bus_q;
  assign wb_stb_o = bus_q;
  assign wb_we_o  = is_write;
  assign wb_adr_o = addr_q;
  assign wb_dat_o = data_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= st_command;
      collect_cnt <= '0;
      bus_q       <= 1'b0;
      ovf_sticky  <= 1'b0;
    end else begin
      ovf_sticky <= (ovf_sticky && !ovf_take) || overflow_i;

      case (state)
        st_command: begin
          collect_cnt <= '0;
          if (ovf_sticky) begin
            resp_q.code     <= wbb_pkg::resp_overflow;
            resp_q.data     <= '0;
            resp_q.has_data <= 1'b0;
            state           <= st_respond;
          end else if (byte_valid_i) begin
            is_write <= (byte_i == wbb_pkg::cmd_write);
            case (byte_i)
              wbb_pkg::cmd_nop: begin
              end
              wbb_pkg::cmd_read, wbb_pkg::cmd_write: begin
                state <= st_collect;
              end
              wbb_pkg::cmd_ping: begin
                resp_q.code     <= wbb_pkg::resp_ping;
                resp_q.data     <= '0;
                resp_q.has_data <= 1'b0;
                state           <= st_respond;
              end
              default: begin
              end
            endcase
          end
        end

        // Address and data arrive low byte first.
        st_collect: begin
          if (byte_valid_i) begin
            collect_cnt <= collect_cnt + 1'b1;
            case (collect_cnt)
              2'd0: addr_q[bw-1:0] <= byte_i;
              2'd1: begin
                addr_q[2*bw-1:bw] <= byte_i;
                if (!is_write) begin
                  bus_q <= 1'b1;
                  state <= st_bus_wait;
                end
              end
              2'd2: data_q[bw-1:0] <= byte_i;
              default: begin
                data_q[2*bw-1:bw] <= byte_i;
                bus_q             <= 1'b1;
                state             <= st_bus_wait;
              end
            endcase
          end
        end

        st_bus_wait: begin
          if (wb_ack_i || wb_err_i) begin
            bus_q           <= 1'b0;
            resp_q.code     <= wb_err_i ? wbb_pkg::resp_buserror : wbb_pkg::resp_ack;
            resp_q.data     <= wb_dat_i;
            resp_q.has_data <= wb_ack_i && !wb_err_i && !is_write;
            state           <= st_respond;
          end
        end

        // Hold the record here while the response queue is full.
        default: begin
          if (!resp_full_i) begin
            state <= st_command;
          end
        end
      endcase
    end
  end

endmodule

// ==== rtl/wbb_credit_fifo.sv ====
`timescale 1ns/1ps

module wbb_credit_fifo #(
  parameter int  DEPTH = 8,
  parameter type T     = logic [7:0]
) (
  input  logic clk,
  input  logic reset,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic valid_o,
  output logic full_o,
  output logic credit_o,
  output logic overflow_o
);

  localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int cnt_w = $clog2(DEPTH + 1);
  localparam logic [ptr_w-1:0] last_slot  = ptr_w'(DEPTH - 1);
  localparam logic [cnt_w-1:0] full_count = cnt_w'(DEPTH);

  T                 mem [DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign valid_o = (count != '0);
  assign full_o  = (count == full_count);
  assign data_o  = mem[rd_ptr];
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && valid_o;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_o   <= 1'b0;
      overflow_o <= 1'b0;
    end else begin
      // Every slot freed is handed back to the producer as one credit.
      credit_o   <= do_pop;
      overflow_o <= push_i && full_o;

      if (do_push) begin
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      end

      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== rtl/wbb_pkg.sv ====
package wbb_pkg;

  // Link and bus widths.
  localparam int byte_w = 8;
  localparam int addr_w = 16;
  localparam int data_w = 16;

  // Command codes as they arrive from the host.
  localparam logic [byte_w-1:0] cmd_nop   = 8'd0;
  localparam logic [byte_w-1:0] cmd_read  = 8'd1;
  localparam logic [byte_w-1:0] cmd_write = 8'd2;
  localparam logic [byte_w-1:0] cmd_ping  = 8'd8;

  // Response codes as they are sent back to the host.
  localparam logic [byte_w-1:0] resp_ack      = 8'd1;
  localparam logic [byte_w-1:0] resp_ping     = 8'd8;
  localparam logic [byte_w-1:0] resp_buserror = 8'd254;
  localparam logic [byte_w-1:0] resp_overflow = 8'd255;

  // One queued response.
  // The data bytes follow the code on the link only when has_data is set,
  // which the parser does for a read ACK alone.
  typedef struct packed {
    logic [byte_w-1:0] code;
    logic [data_w-1:0] data;
    logic              has_data;
  } resp_t;

endpackage

// ==== rtl/wbb_reg_slave.sv ====
`timescale 1ns/1ps

module wbb_reg_slave #(
  parameter int MEM_WORDS = 16
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [wbb_pkg::addr_w-1:0]  wb_adr_i,
  input  logic [wbb_pkg::data_w-1:0]  wb_dat_i,
  output logic [wbb_pkg::data_w-1:0]  wb_dat_o,
  output logic                        wb_ack_o,
  output logic                        wb_err_o
);

  localparam int aw    = wbb_pkg::addr_w;
  localparam int idx_w = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam logic [aw-1:0] mem_limit = aw'(MEM_WORDS);

  logic [wbb_pkg::data_w-1:0] mem [MEM_WORDS];
  logic                       req;
  logic                       in_range;
  logic [idx_w-1:0]           idx;

  // A request is new until this slave has answered it once.
  assign req      = wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o;
  assign in_range = (wb_adr_i < mem_limit);
  assign idx      = wb_adr_i[idx_w-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      wb_ack_o <= req && in_range;
      wb_err_o <= req && !in_range;
      if (req && in_range) begin
        if (wb_we_i) begin
          mem[idx] <= wb_dat_i;
        end else begin
          wb_dat_o <= mem[idx];
        end
      end
    end
  end

endmodule

// ==== rtl/wbb_resp_serializer.sv ====
`timescale 1ns/1ps

module wbb_resp_serializer #(
  parameter int OUT_CREDITS = 4
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        rec_valid_i,
  input  wbb_pkg::resp_t              rec_i,
  output logic                        rec_pop_o,
  output logic                        out_valid_o,
  output logic [wbb_pkg::byte_w-1:0]  out_data_o,
  input  logic                        out_credit_i
);

  localparam int bw   = wbb_pkg::byte_w;
  localparam int cr_w = $clog2(OUT_CREDITS + 1);
  localparam logic [cr_w-1:0] init_credits = cr_w'(OUT_CREDITS);

  wbb_pkg::resp_t   rec_q;
  logic             busy;
  logic [1:0]       idx;
  logic [cr_w-1:0]  credits;
  logic             send;
  logic             send_last;
  logic             start;
  logic [bw-1:0]    cur_byte;

  assign send      = busy && (credits != '0);
  assign send_last = send && ((idx == 2'd2) || !rec_q.has_data);

  // The next record is taken in the cycle the current one sends its last byte.
  assign start     = rec_valid_i && (!busy || send_last);
  assign rec_pop_o = start;

  always_comb begin
    case (idx)
      2'd1:    cur_byte = rec_q.data[bw-1:0];
      2'd2:    cur_byte = rec_q.data[2*bw-1:bw];
      default: cur_byte = rec_q.code;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy        <= 1'b0;
      idx         <= '0;
      credits     <= init_credits;
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= send;
      if (send) begin
        out_data_o <= cur_byte;
      end

      case ({send, out_credit_i})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: begin
        end
      endcase

      if (start) begin
        rec_q <= rec_i;
        busy  <= 1'b1;
        idx   <= '0;
      end else if (send_last) begin
        busy <= 1'b0;
        idx  <= '0;
      end else if (send) begin
        idx <= idx + 1'b1;
      end
    end
  end

endmodule

// ==== tb/wbb_checker.sv ====
`timescale 1ns/1ps

module wbb_checker #(
  parameter int IN_DEPTH    = 8,
  parameter int OUT_CREDITS = 4
) (
  input logic clk,
  input logic reset,
  input logic in_valid_i,
  input logic in_credit_i,
  input logic out_valid_i,
  input logic out_credit_i,
  input logic wb_stb_i,
  input logic wb_ack_i,
  input logic wb_err_i
);

  // Credits as seen from the host side of each link.
  int host_credits;
  int link_credits;

  always_ff @(posedge clk) begin
    if (reset) begin
      host_credits <= IN_DEPTH;
      link_credits <= OUT_CREDITS;
    end else begin
      host_credits <= host_credits - int'(in_valid_i) + int'(in_credit_i);
      link_credits <= link_credits - int'(out_valid_i) + int'(out_credit_i);
    end
  end

  // The bridge never hands back more in-credits than the bytes it was given.
  assert property (@(posedge clk) disable iff (reset) host_credits <= IN_DEPTH)
    else $error("in-credits returned beyond the input queue depth");

  assert property (@(posedge clk) disable iff (reset) out_valid_i |-> link_credits > 0)
    else $error("response byte sent without an out-credit");

  assert property (@(posedge clk) disable iff (reset)
    wb_stb_i && !wb_ack_i && !wb_err_i |=> wb_stb_i)
    else $error("stb dropped before ack or err");

  assert property (@(posedge clk) disable iff (reset) !(wb_ack_i && wb_err_i))
    else $error("ack and err high together");

endmodule

bind wbb_bridge_top wbb_checker #(
  .IN_DEPTH    (IN_DEPTH),
  .OUT_CREDITS (OUT_CREDITS)
) i_checker (
  .clk          (clk),
  .reset        (reset),
  .in_valid_i   (in_valid_i),
  .in_credit_i  (in_credit_o),
  .out_valid_i  (out_valid_o),
  .out_credit_i (out_credit_i),
  .wb_stb_i     (wb_stb),
  .wb_ack_i     (wb_ack),
  .wb_err_i     (wb_err)
);

// ==== tb/wbb_clk_gen.sv ====
`timescale 1ns/1ps

module wbb_clk_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset is released on a falling edge, like every other DUT input.
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== tb/wbb_tb.sv ====
`timescale 1ns/1ps

module wbb_tb;

  localparam int IN_DEPTH    = 8;
  localparam int RESP_DEPTH  = 4;
  localparam int OUT_CREDITS = 4;
  localparam int MEM_WORDS   = 16;
  localparam int mem_aw      = $clog2(MEM_WORDS);
  localparam logic [15:0] lfsr_seed = 16'd19416;
  localparam int cycle_budget = 24;
  localparam int hold_short   = 40;
  localparam int hold_long    = 80;
  localparam int no_resp      = -1;
  localparam int mode_plain   = 0;
  localparam int mode_hold    = 1;
  localparam int mode_flood   = 2;
  // Pings that fill the serializer, both queues and the parser, then the input queue.
  localparam int flood_len = OUT_CREDITS + RESP_DEPTH + 2 + IN_DEPTH;

  typedef struct packed {
    logic [7:0]  code;
    logic [15:0] addr;
    logic [15:0] data;
    logic [8:0]  resp;
    logic [1:0]  mode;
  } entry_t;

  logic        clk;
  logic        reset;
  logic        in_valid;
  logic [7:0]  in_data;
  logic        in_credit;
  logic        out_valid;
  logic [7:0]  out_data;
  logic        out_credit;

  entry_t      tab[$];
  logic [8:0]  send_q[$];
  logic [7:0]  exp_q[$];
  logic [15:0] ref_mem [MEM_WORDS];
  logic [15:0] lfsr;
  int          in_credits;
  int          owed;
  int          gap;
  int          hold_cnt;
  int          zero_cycles;
  int          cycles;
  int          cycle_limit;

  wbb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  wbb_bridge_top #(
    .IN_DEPTH    (IN_DEPTH),
    .RESP_DEPTH  (RESP_DEPTH),
    .OUT_CREDITS (OUT_CREDITS),
    .MEM_WORDS   (MEM_WORDS)
  ) i_dut (
    .clk          (clk),
    .reset        (reset),
    .in_valid_i   (in_valid),
    .in_data_i    (in_data),
    .in_credit_o  (in_credit),
    .out_valid_o  (out_valid),
    .out_data_o   (out_data),
    .out_credit_i (out_credit)
  );

  task automatic end_with_failure();
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic compare(input logic [7:0] expected, input logic [7:0] actual,
                         input string what);
    if (expected !== actual) begin
      $display("Mismatch at time %0t: %s expected %0d, got %0d", $time, what, expected,
               actual);
      end_with_failure();
    end
  endtask

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output int val);
    val = 0;
    for (int k = 0; k < n; k++) begin
      val = (val << 1) | int'(lfsr[0]);
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic add_entry(input logic [7:0] code, input logic [15:0] addr,
                           input logic [15:0] data, input int resp, input int mode);
    logic [8:0] r;
    r = (resp < 0) ? 9'h100 : {1'b0, 8'(resp)};
    tab.push_back({code, addr, data, r, 2'(mode)});
  endtask

  task automatic build_table();
    add_entry(wbb_pkg::cmd_ping, 16'h0000, 16'h0000, wbb_pkg::resp_ping, mode_plain);
    add_entry(wbb_pkg::cmd_nop, 16'h0000, 16'h0000, no_resp, mode_plain);
    add_entry(wbb_pkg::cmd_ping, 16'h0000, 16'h0000, wbb_pkg::resp_ping, mode_plain);
    add_entry(wbb_pkg::cmd_write, 16'h0003, 16'ha55a, wbb_pkg::resp_ack, mode_plain);
    add_entry(wbb_pkg::cmd_read, 16'h0003, 16'h0000, wbb_pkg::resp_ack, mode_plain);
    add_entry(wbb_pkg::cmd_read, 16'h0007, 16'h0000, wbb_pkg::resp_ack, mode_plain);
    add_entry(wbb_pkg::cmd_read, 16'h0010, 16'h0000, wbb_pkg::resp_buserror, mode_plain);
    // Index 3 again if the slave ignored the upper address bits.
    add_entry(wbb_pkg::cmd_write, 16'h0103, 16'h1234, wbb_pkg::resp_buserror, mode_plain);
    add_entry(wbb_pkg::cmd_read, 16'h0003, 16'h0000, wbb_pkg::resp_ack, mode_plain);
    add_entry(8'h5a, 16'h0000, 16'h0000, no_resp, mode_plain);
    add_entry(wbb_pkg::cmd_ping, 16'h0000, 16'h0000, wbb_pkg::resp_ping, mode_plain);
    add_entry(wbb_pkg::cmd_write, 16'h000f, 16'hbeef, wbb_pkg::resp_ack, mode_hold);
    add_entry(wbb_pkg::cmd_read, 16'h000f, 16'h0000, wbb_pkg::resp_ack, mode_plain);
    add_entry(wbb_pkg::cmd_write, 16'h0000, 16'h0102, wbb_pkg::resp_ack, mode_plain);
    add_entry(wbb_pkg::cmd_read, 16'h0000, 16'h0000, wbb_pkg::resp_ack, mode_plain);
    add_entry(wbb_pkg::cmd_ping, 16'h0000, 16'h0000, wbb_pkg::resp_ping, mode_plain);
    add_entry(wbb_pkg::cmd_ping, 16'h0000, 16'h0000, wbb_pkg::resp_ping, mode_flood);
    add_entry(wbb_pkg::cmd_ping, 16'h0000, 16'h0000, wbb_pkg::resp_ping, mode_plain);
    add_entry(wbb_pkg::cmd_read, 16'h000f, 16'h0000, wbb_pkg::resp_ack, mode_plain);
  endtask

  // Expands one entry into link bytes and expected response bytes.
  task automatic queue_entry(input entry_t e);
    if (e.mode == mode_flood) begin
      for (int k = 0; k < flood_len; k++) begin
        send_q.push_back({1'b0, e.code});
        exp_q.push_back(e.resp[7:0]);
        // The report follows the ping that the stalled parser was holding.
        if (k == flood_len - IN_DEPTH - 1) begin
          exp_q.push_back(wbb_pkg::resp_overflow);
        end
      end
      send_q.push_back({1'b1, e.code});
    end else begin
      send_q.push_back({1'b0, e.code});
      if (e.code == wbb_pkg::cmd_read || e.code == wbb_pkg::cmd_write) begin
        send_q.push_back({1'b0, e.addr[7:0]});
        send_q.push_back({1'b0, e.addr[15:8]});
      end
      if (e.code == wbb_pkg::cmd_write) begin
        send_q.push_back({1'b0, e.data[7:0]});
        send_q.push_back({1'b0, e.data[15:8]});
      end
      if (!e.resp[8]) begin
        exp_q.push_back(e.resp[7:0]);
      end
      if (e.resp[7:0] == wbb_pkg::resp_ack && e.code == wbb_pkg::cmd_write) begin
        ref_mem[e.addr[mem_aw-1:0]] = e.data;
      end else if (e.resp[7:0] == wbb_pkg::resp_ack) begin
        exp_q.push_back(ref_mem[e.addr[mem_aw-1:0]][7:0]);
        exp_q.push_back(ref_mem[e.addr[mem_aw-1:0]][15:8]);
      end
    end
  endtask

  // Host side of both links.
  always @(negedge clk) begin : host_model
    logic [8:0] nxt;
    if (reset === 1'b0) begin
      if (in_credit) begin
        in_credits++;
      end
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          $display("Error at time %0t: byte %0d arrived with no response pending.", $time,
                   out_data);
          end_with_failure();
        end else begin
          compare(exp_q.pop_front(), out_data, "response byte");
        end
        owed++;
      end

      in_valid = 1'b0;
      if (send_q.size() > 0) begin
        // A marked byte is pushed without a credit once the input queue has stayed full.
        if (send_q[0][8] && zero_cycles >= 8) begin
          nxt = send_q.pop_front();
          in_valid = 1'b1;
          in_data = nxt[7:0];
        end else if (!send_q[0][8] && in_credits > 0) begin
          nxt = send_q.pop_front();
          in_valid = 1'b1;
          in_data = nxt[7:0];
          in_credits--;
        end
      end
      zero_cycles = (in_credits == 0 && !in_credit) ? zero_cycles + 1 : 0;

      out_credit = 1'b0;
      if (hold_cnt > 0) begin
        hold_cnt--;
      end else if (owed > 0) begin
        if (gap > 0) begin
          gap--;
        end else begin
          out_credit = 1'b1;
          owed--;
          rand_bits(2, gap);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Error at time %0t: timeout, the run took more than %0d cycles.", $time,
               cycle_limit);
      end_with_failure();
    end
  end

  initial begin
    int total;
    in_valid    = 1'b0;
    in_data     = '0;
    out_credit  = 1'b0;
    lfsr        = lfsr_seed;
    in_credits  = IN_DEPTH;
    owed        = 0;
    gap         = 0;
    hold_cnt    = 0;
    zero_cycles = 0;
    cycles      = 0;
    cycle_limit = 0;
    total       = 0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      ref_mem[a] = '0;
    end
    build_table();

    // Link bytes in both directions, with the read and write payloads counted in full.
    foreach (tab[i]) begin
      total += (tab[i].mode == mode_flood) ? 2 * flood_len + 2 : 8;
    end
    cycle_limit = total * cycle_budget + hold_short + hold_long;

    wait (reset === 1'b0);
    foreach (tab[i]) begin
      if (tab[i].mode != mode_plain) begin
        wait (send_q.size() == 0 && exp_q.size() == 0 && owed == 0);
        hold_cnt = (tab[i].mode == mode_flood) ? hold_long : hold_short;
      end
      queue_entry(tab[i]);
    end

    wait (send_q.size() == 0 && exp_q.size() == 0);
    repeat (20) @(negedge clk);
    // The dropped byte took no credit, so the host ends holding every input credit.
    if (in_credits == IN_DEPTH) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("Mismatch at time %0t: host holds %0d input credits, expected %0d.", $time,
               in_credits, IN_DEPTH);
      end_with_failure();
    end
  end

endmodule

// ==== wbb.f ====
rtl/wbb_pkg.sv
rtl/wbb_credit_fifo.sv
rtl/wbb_cmd_parser.sv
rtl/wbb_resp_serializer.sv
rtl/wbb_reg_slave.sv
rtl/wbb_bridge_top.sv
tb/wbb_clk_gen.sv
tb/wbb_checker.sv
tb/wbb_tb.sv
